//--- Makefile
# Verilator build and run of the AXI RAM testbench
VERILATOR ?= verilator
TOP       ?= tb_axi_ram
FILELIST  ?= axi_ram.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- axi_ram.f
hw/axi_ram_pkg.sv
hw/burst_addr_gen.sv
hw/ram_pseudo_dual.sv
hw/axi_write_channel.sv
hw/axi_read_channel.sv
hw/axi_ram.sv
verification/axi_ram_properties.sv
verification/tb_axi_ram.sv

//--- hw/axi_ram.sv
// AXI4 slave in front of a pseudo-dual-port word RAM.
// write and read engines each own one RAM port, so both channels run
// concurrently without arbitration. MEM_AW sets the RAM size in words.
`timescale 1ns/1ns

module axi_ram import axi_ram_pkg::*; #(
    parameter int MEM_AW      = 10,
    parameter int RFIFO_DEPTH = 4
) (
    input  logic    S_AXI_ACLK,
    input  logic    S_AXI_ARESETN,
    input  axi_aw_t aw,
    input  logic    aw_valid,
    output logic    aw_ready,
    input  axi_w_t  w,
    input  logic    w_valid,
    output logic    w_ready,
    output axi_b_t  b,
    output logic    b_valid,
    input  logic    b_ready,
    input  axi_ar_t ar,
    input  logic    ar_valid,
    output logic    ar_ready,
    output axi_r_t  r,
    output logic    r_valid,
    input  logic    r_ready
);

    logic              ram_we;
    logic [STRB_W-1:0] ram_wmask;
    logic [MEM_AW-1:0] ram_waddr;
    logic [DATA_W-1:0] ram_wdata;
    logic              ram_re;
    logic [MEM_AW-1:0] ram_raddr;
    logic [DATA_W-1:0] ram_rdata;

    axi_write_channel #(.MEM_AW(MEM_AW)) u_wr (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .aw           (aw),
        .aw_valid     (aw_valid),
        .aw_ready     (aw_ready),
        .w            (w),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .b            (b),
        .b_valid      (b_valid),
        .b_ready      (b_ready),
        .ram_we       (ram_we),
        .ram_wmask    (ram_wmask),
        .ram_waddr    (ram_waddr),
        .ram_wdata    (ram_wdata)
    );

    axi_read_channel #(.MEM_AW(MEM_AW), .RFIFO_DEPTH(RFIFO_DEPTH)) u_rd (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .ar           (ar),
        .ar_valid     (ar_valid),
        .ar_ready     (ar_ready),
        .r            (r),
        .r_valid      (r_valid),
        .r_ready      (r_ready),
        .ram_re       (ram_re),
        .ram_raddr    (ram_raddr),
        .ram_rdata    (ram_rdata)
    );

    ram_pseudo_dual #(.MEM_AW(MEM_AW)) u_ram (
        .S_AXI_ACLK(S_AXI_ACLK),
        .we        (ram_we),
        .wmask     (ram_wmask),
        .waddr     (ram_waddr),
        .wdata     (ram_wdata),
        .re        (ram_re),
        .raddr     (ram_raddr),
        .rdata     (ram_rdata)
    );

endmodule

//--- hw/axi_ram_pkg.sv
// shared widths, AXI channel payload structs and FSM state types
// for the AXI4 RAM slave. every hw module pulls this in by wildcard
// import in its header.
package axi_ram_pkg;

    localparam int ID_W       = 4;
    localparam int ADDR_W     = 16;          // byte address
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int LEN_W      = 8;
    localparam int BYTE_SHIFT = 2;           // byte addr -> word index

    // reserved code 2'b11 falls through to INCR handling
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_t;

    typedef enum logic [1:0] {
        RESP_OKAY = 2'b00
    } resp_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [LEN_W-1:0]  len;   // beats - 1
        burst_t            burst;
    } axi_aw_t;

    typedef axi_aw_t axi_ar_t;    // same layout on the read side

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
        logic              last;
    } axi_w_t;

    typedef struct packed {
        logic [ID_W-1:0] id;
        resp_t           resp;
    } axi_b_t;

    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_t             resp;
        logic              last;
    } axi_r_t;

    typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wr_state_t;
    typedef enum logic {RD_IDLE, RD_ISSUE} rd_state_t;

endpackage

//--- hw/axi_read_channel.sv
// AR/R engine of the AXI RAM slave. issues one RAM read per cycle while
// FIFO space allows, tags each returning word with id and last, and
// queues it in a small FIFO whose head drives the R channel.
`timescale 1ns/1ns

module axi_read_channel import axi_ram_pkg::*; #(
    parameter int MEM_AW      = 10,
    parameter int RFIFO_DEPTH = 4
) (
    input  logic              S_AXI_ACLK,
    input  logic              S_AXI_ARESETN,
    input  axi_ar_t           ar,
    input  logic              ar_valid,
    output logic              ar_ready,
    output axi_r_t            r,
    output logic              r_valid,
    input  logic              r_ready,
    output logic              ram_re,
    output logic [MEM_AW-1:0] ram_raddr,
    input  logic [DATA_W-1:0] ram_rdata
);

    localparam int PTR_W = $clog2(RFIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    rd_state_t         state;
    logic [ID_W-1:0]   id_q;
    logic              ar_fire;
    logic              issue;
    logic [ADDR_W-1:0] beat_addr;
    logic              beat_last;

    // one-cycle side band that travels with the RAM read
    logic              pipe_v;
    logic [ID_W-1:0]   pipe_id;
    logic              pipe_last;

    axi_r_t            fifo_mem [RFIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              pop;

    assign ar_ready = (state == RD_IDLE);
    assign ar_fire  = ar_valid && ar_ready;

    // credit check counts the word still coming out of the RAM
    assign issue = (state == RD_ISSUE) && ((count + CNT_W'(pipe_v)) < CNT_W'(RFIFO_DEPTH));

    burst_addr_gen u_addr_gen (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .start        (ar_fire),
        .start_addr   (ar.addr),
        .start_len    (ar.len),
        .start_burst  (ar.burst),
        .step         (issue),
        .addr         (beat_addr),
        .last_beat    (beat_last)
    );

    assign ram_re    = issue;
    assign ram_raddr = beat_addr[BYTE_SHIFT +: MEM_AW];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state  <= RD_IDLE;
            pipe_v <= 1'b0;
        end else begin
            pipe_v <= issue;
            case (state)
                RD_IDLE:  if (ar_fire) state <= RD_ISSUE;
                RD_ISSUE: if (issue && beat_last) state <= RD_IDLE;   // earlier beats may still drain
                default:  state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (ar_fire)
            id_q <= ar.id;
        pipe_id   <= id_q;
        pipe_last <= beat_last;
    end

    // read data FIFO
    assign pop     = r_valid && r_ready;
    assign r_valid = (count != '0);
    assign r       = fifo_mem[rd_ptr];

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (pipe_v)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(pipe_v) - CNT_W'(pop);
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (pipe_v)
            fifo_mem[wr_ptr] <= '{id: pipe_id, data: ram_rdata, resp: RESP_OKAY,
                                  last: pipe_last};
    end

endmodule

//--- hw/axi_write_channel.sv
// AW/W/B engine of the AXI RAM slave. takes one write burst at a time,
// writes each W beat straight into the RAM write port and then holds
// the B response until the master accepts it.
`timescale 1ns/1ns

module axi_write_channel import axi_ram_pkg::*; #(
    parameter int MEM_AW = 10
) (
    input  logic              S_AXI_ACLK,
    input  logic              S_AXI_ARESETN,
    input  axi_aw_t           aw,
    input  logic              aw_valid,
    output logic              aw_ready,
    input  axi_w_t            w,
    input  logic              w_valid,
    output logic              w_ready,
    output axi_b_t            b,
    output logic              b_valid,
    input  logic              b_ready,
    output logic              ram_we,
    output logic [STRB_W-1:0] ram_wmask,
    output logic [MEM_AW-1:0] ram_waddr,
    output logic [DATA_W-1:0] ram_wdata
);

    wr_state_t         state;
    logic [ID_W-1:0]   id_q;
    logic              aw_fire;
    logic              w_fire;
    logic [ADDR_W-1:0] beat_addr;
    logic              beat_last;

    assign aw_ready = (state == WR_IDLE);
    assign w_ready  = (state == WR_DATA);
    assign b_valid  = (state == WR_RESP);
    assign aw_fire  = aw_valid && aw_ready;
    assign w_fire   = w_valid && w_ready;

    burst_addr_gen u_addr_gen (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .start        (aw_fire),
        .start_addr   (aw.addr),
        .start_len    (aw.len),
        .start_burst  (aw.burst),
        .step         (w_fire && !beat_last),   // overlong burst stays on last word
        .addr         (beat_addr),
        .last_beat    (beat_last)
    );

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: if (aw_fire) state <= WR_DATA;
                WR_DATA: if (w_fire && w.last) state <= WR_RESP;   // WLAST ends the burst
                WR_RESP: if (b_ready) state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (aw_fire)
            id_q <= aw.id;
    end

    assign b = '{id: id_q, resp: RESP_OKAY};

    // RAM write happens on the W handshake edge
    assign ram_we    = w_fire;
    assign ram_wmask = w.strb;
    assign ram_wdata = w.data;
    assign ram_waddr = beat_addr[BYTE_SHIFT +: MEM_AW];   // aliases above RAM size

endmodule

//--- hw/burst_addr_gen.sv
// beat address and beat counter for one AXI burst.
// load with start, then pulse step once per beat; addr is the current
// beat address and last_beat flags the final beat of the burst.
`timescale 1ns/1ns

module burst_addr_gen import axi_ram_pkg::*; (
    input  logic              S_AXI_ACLK,
    input  logic              S_AXI_ARESETN,
    input  logic              start,
    input  logic [ADDR_W-1:0] start_addr,
    input  logic [LEN_W-1:0]  start_len,
    input  burst_t            start_burst,
    input  logic              step,
    output logic [ADDR_W-1:0] addr,
    output logic              last_beat
);

    logic [LEN_W-1:0]  len_q;
    logic [LEN_W-1:0]  beat_q;
    burst_t            burst_q;
    logic [ADDR_W-1:0] wrap_mask;
    logic [ADDR_W-1:0] incr_addr;
    logic [ADDR_W-1:0] next_addr;

    // window of (len+1) words, low bits free to move
    assign wrap_mask = ((ADDR_W'(len_q) + 1'b1) << BYTE_SHIFT) - 1'b1;
    assign incr_addr = addr + ADDR_W'(STRB_W);

    always_comb begin
        case (burst_q)
            BURST_FIXED: next_addr = addr;
            BURST_WRAP:  next_addr = (addr & ~wrap_mask) | (incr_addr & wrap_mask);
            default:     next_addr = incr_addr;   // INCR and reserved
        endcase
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (!S_AXI_ARESETN) begin
            beat_q  <= '0;
            len_q   <= '0;
            burst_q <= BURST_INCR;
        end else if (start) begin
            beat_q  <= '0;
            len_q   <= start_len;
            burst_q <= start_burst;
        end else if (step) begin
            beat_q <= beat_q + 1'b1;
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (start)
            addr <= start_addr;
        else if (step)
            addr <= next_addr;
    end

    assign last_beat = (beat_q == len_q);

endmodule

//--- hw/ram_pseudo_dual.sv
// word RAM with one byte-masked write port and one read port.
// read data is registered and shows up the cycle after re.
`timescale 1ns/1ns

module ram_pseudo_dual import axi_ram_pkg::*; #(
    parameter int MEM_AW = 10
) (
    input  logic              S_AXI_ACLK,
    input  logic              we,
    input  logic [STRB_W-1:0] wmask,
    input  logic [MEM_AW-1:0] waddr,
    input  logic [DATA_W-1:0] wdata,
    input  logic              re,
    input  logic [MEM_AW-1:0] raddr,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0] mem [2**MEM_AW];

    always_ff @(posedge S_AXI_ACLK) begin
        if (we) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wmask[i])
                    mem[waddr][i*8 +: 8] <= wdata[i*8 +: 8];   // strobed byte lanes only
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK) begin
        if (re)
            rdata <= mem[raddr];   // holds last word otherwise
    end

endmodule

//--- verification/axi_ram_properties.sv
// AXI protocol checks for the RAM slave, bound into axi_ram.
// covers R/B hold under back-pressure, the post-reset state and AW/B exclusion.
// failures are also tallied in fail_cnt
`timescale 1ns/1ns

module axi_ram_properties import axi_ram_pkg::*; (
    input logic   S_AXI_ACLK,
    input logic   S_AXI_ARESETN,
    input logic   aw_ready,
    input logic   w_ready,
    input logic   ram_we,
    input axi_b_t b,
    input logic   b_valid,
    input logic   b_ready,
    input axi_r_t r,
    input logic   r_valid,
    input logic   r_ready
);

    int unsigned fail_cnt = 0;

    // stalled R beat must not change or drop
    r_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        r_valid && !r_ready |=> r_valid && $stable(r))
        else begin
            $error("R beat changed while stalled");
            fail_cnt++;
        end

    b_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        b_valid && !b_ready |=> b_valid && $stable(b))
        else begin
            $error("B response changed while stalled");
            fail_cnt++;
        end

    reset_quiet: assert property (@(posedge S_AXI_ACLK)
        !S_AXI_ARESETN |=> !b_valid && !r_valid && !w_ready && !ram_we)
        else begin
            $error("outputs active in the cycle after reset");
            fail_cnt++;
        end

    // one burst at a time on the write side
    aw_blocked: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        !(aw_ready && b_valid))
        else begin
            $error("aw_ready high with a pending B response");
            fail_cnt++;
        end

endmodule

bind axi_ram axi_ram_properties u_props (
    .S_AXI_ACLK   (S_AXI_ACLK),
    .S_AXI_ARESETN(S_AXI_ARESETN),
    .aw_ready     (aw_ready),
    .w_ready      (w_ready),
    .ram_we       (ram_we),
    .b            (b),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .r            (r),
    .r_valid      (r_valid),
    .r_ready      (r_ready)
);

//--- verification/tb_axi_ram.sv
// testbench for the AXI4 RAM slave. runs INCR, WRAP and FIXED bursts,
// keeps a byte image of the RAM as reference and checks every B response
// and R beat against it, with optional random B/R back-pressure.
`timescale 1ns/1ns

module tb_axi_ram import axi_ram_pkg::*; ();

    localparam int TIMEOUT = 200;   // cycles per handshake
    localparam int CH_AW   = 0;
    localparam int CH_W    = 1;
    localparam int CH_B    = 2;
    localparam int CH_AR   = 3;
    localparam int CH_R    = 4;

    logic    S_AXI_ACLK;
    logic    S_AXI_ARESETN;
    axi_aw_t aw;
    logic    aw_valid;
    logic    aw_ready;
    axi_w_t  w;
    logic    w_valid;
    logic    w_ready;
    axi_b_t  b;
    logic    b_valid;
    logic    b_ready;
    axi_ar_t ar;
    logic    ar_valid;
    logic    ar_ready;
    axi_r_t  r;
    logic    r_valid;
    logic    r_ready;

    logic [7:0] ref_mem [4096];   // byte image, 4 KB like the RAM
    axi_b_t     got_b;
    axi_r_t     got_r;
    bit         stall;
    int         errors;
    int         err_mark;
    int         tests_run;
    int         tests_bad;

    axi_ram #(.MEM_AW(10), .RFIFO_DEPTH(4)) u_axi_ram (.*);

    initial begin
        S_AXI_ACLK = 1'b0;
        forever #4 S_AXI_ACLK = ~S_AXI_ACLK;
    end

    function automatic logic fired(input int ch);
        case (ch)
            CH_AW:   return aw_valid && aw_ready;
            CH_W:    return w_valid && w_ready;
            CH_B:    return b_valid && b_ready;
            CH_AR:   return ar_valid && ar_ready;
            default: return r_valid && r_ready;
        endcase
    endfunction

    // next beat address per AXI burst rules
    function automatic logic [ADDR_W-1:0] step_addr(input logic [ADDR_W-1:0] a,
                                                    input int beats, input burst_t burst);
        int size;
        int base;
        size = beats * 4;
        base = (int'(a) / size) * size;
        case (burst)
            BURST_FIXED: return a;
            BURST_WRAP:  return ADDR_W'(base + (int'(a) - base + 4) % size);
            default:     return a + ADDR_W'(4);
        endcase
    endfunction

    function automatic logic [DATA_W-1:0] ref_word(input logic [ADDR_W-1:0] a);
        return {ref_mem[{a[11:2], 2'd3}], ref_mem[{a[11:2], 2'd2}],
                ref_mem[{a[11:2], 2'd1}], ref_mem[{a[11:2], 2'd0}]};
    endfunction

    task automatic ref_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                             input logic [STRB_W-1:0] s);
        for (int k = 0; k < STRB_W; k++) begin
            if (s[k])
                ref_mem[{a[11:2], 2'(k)}] = d[k*8 +: 8];
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        assert (got === exp) else begin
            $display("[FAIL] %s expected 0x%h got 0x%h", name, exp, got);
            errors++;
        end
    endtask

    task automatic finish_run();
        int prop_fails;
        prop_fails = int'(u_axi_ram.u_props.fail_cnt);
        $display("tests run %0d, with errors %0d, check errors %0d, property errors %0d",
                 tests_run, tests_bad, errors, prop_fails);
        if (errors == 0 && prop_fails == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    endtask

    task automatic set_ready(input int ch);
        if (ch == CH_B)
            b_ready <= stall ? 1'($urandom) : 1'b1;
        else if (ch == CH_R)
            r_ready <= stall ? 1'($urandom) : 1'b1;
    endtask

    // called just after a rising edge, returns just after the transfer edge
    task automatic wait_xfer(input int ch, input string what);
        int t;
        t = 0;
        set_ready(ch);
        @(negedge S_AXI_ACLK);
        while (!fired(ch) && t < TIMEOUT) begin
            @(posedge S_AXI_ACLK);
            set_ready(ch);
            @(negedge S_AXI_ACLK);
            t++;
        end
        if (!fired(ch)) begin
            $display("timeout: no %s handshake within %0d cycles", what, TIMEOUT);
            errors++;
        end else begin
            got_b = b;   // sampled mid-cycle, stable
            got_r = r;
        end
        @(posedge S_AXI_ACLK);
    endtask

    task automatic write_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                               input int beats, input burst_t burst, input bit rand_strb);
        logic [ADDR_W-1:0] a;
        logic [DATA_W-1:0] d;
        logic [STRB_W-1:0] s;
        a = addr;
        aw <= '{id: id, addr: addr, len: LEN_W'(beats - 1), burst: burst};
        aw_valid <= 1'b1;
        wait_xfer(CH_AW, "AW");
        aw_valid <= 1'b0;
        for (int i = 0; i < beats; i++) begin
            d = $urandom;
            s = rand_strb ? STRB_W'($urandom) : '1;
            w <= '{data: d, strb: s, last: (i == beats - 1)};
            w_valid <= 1'b1;
            wait_xfer(CH_W, "W");
            ref_write(a, d, s);
            a = step_addr(a, beats, burst);
        end
        w_valid <= 1'b0;
        wait_xfer(CH_B, "B");
        b_ready <= 1'b0;
        check_val("b.id", 32'(id), 32'(got_b.id));
        check_val("b.resp", 32'(RESP_OKAY), 32'(got_b.resp));
    endtask

    task automatic send_ar(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                           input int beats, input burst_t burst);
        ar <= '{id: id, addr: addr, len: LEN_W'(beats - 1), burst: burst};
        ar_valid <= 1'b1;
        wait_xfer(CH_AR, "AR");
        ar_valid <= 1'b0;
    endtask

    task automatic collect_r(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                             input int beats, input burst_t burst);
        logic [ADDR_W-1:0] a;
        a = addr;
        for (int i = 0; i < beats; i++) begin
            wait_xfer(CH_R, "R");
            check_val("r.data", ref_word(a), got_r.data);
            check_val("r.id", 32'(id), 32'(got_r.id));
            check_val("r.resp", 32'(RESP_OKAY), 32'(got_r.resp));
            check_val("r.last", 32'(i == beats - 1), 32'(got_r.last));
            a = step_addr(a, beats, burst);
        end
        r_ready <= 1'b0;
    endtask

    task automatic read_burst(input logic [ID_W-1:0] id, input logic [ADDR_W-1:0] addr,
                              input int beats, input burst_t burst);
        send_ar(id, addr, beats, burst);
        collect_r(id, addr, beats, burst);
    endtask

    task automatic begin_test();
        @(posedge S_AXI_ACLK);
        err_mark = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        end
    endtask

    initial begin
        void'($urandom(20438));
        S_AXI_ARESETN <= 1'b0;
        aw       <= '0;
        aw_valid <= 1'b0;
        w        <= '0;
        w_valid  <= 1'b0;
        b_ready  <= 1'b0;
        ar       <= '0;
        ar_valid <= 1'b0;
        r_ready  <= 1'b0;
        stall     = 1'b0;
        errors    = 0;
        tests_run = 0;
        tests_bad = 0;
        repeat (5) @(posedge S_AXI_ACLK);
        S_AXI_ARESETN <= 1'b1;

        begin_test();
        @(negedge S_AXI_ACLK);
        check_val("aw_ready", 32'd1, 32'(aw_ready));
        check_val("ar_ready", 32'd1, 32'(ar_ready));
        check_val("b_valid", 32'd0, 32'(b_valid));
        check_val("r_valid", 32'd0, 32'(r_valid));
        check_val("w_ready", 32'd0, 32'(w_ready));
        end_test("reset state");

        begin_test();
        write_burst(4'h1, 16'h0040, 8, BURST_INCR, 1'b0);   // full-word fill first
        write_burst(4'h2, 16'h0040, 8, BURST_INCR, 1'b1);
        read_burst(4'h4, 16'h0040, 8, BURST_INCR);
        end_test("incr write and read");

        begin_test();
        write_burst(4'h3, 16'h0100, 4, BURST_INCR, 1'b0);
        read_burst(4'h5, 16'h0108, 4, BURST_WRAP);          // 8, 12, 0, 4
        write_burst(4'h6, 16'h0200, 4, BURST_INCR, 1'b0);
        write_burst(4'h7, 16'h0208, 4, BURST_WRAP, 1'b1);
        read_burst(4'h8, 16'h0200, 4, BURST_INCR);
        end_test("wrap order");

        begin_test();
        write_burst(4'h9, 16'h0080, 1, BURST_INCR, 1'b0);
        write_burst(4'hA, 16'h0080, 4, BURST_FIXED, 1'b1);
        read_burst(4'hB, 16'h0080, 4, BURST_FIXED);
        end_test("fixed burst");

        begin_test();
        write_burst(4'hC, 16'h00C0, 2, BURST_INCR, 1'b0);
        send_ar(4'h3, 16'h0040, 2, BURST_INCR);   // both fit the FIFO with r_ready low
        send_ar(4'hD, 16'h0100, 2, BURST_INCR);
        collect_r(4'h3, 16'h0040, 2, BURST_INCR);
        collect_r(4'hD, 16'h0100, 2, BURST_INCR);
        end_test("ids and responses");

        begin_test();
        stall = 1'b1;
        write_burst(4'hE, 16'h0300, 16, BURST_INCR, 1'b0);
        write_burst(4'h0, 16'h0300, 16, BURST_INCR, 1'b1);
        read_burst(4'hF, 16'h0300, 16, BURST_INCR);
        stall = 1'b0;
        end_test("back-pressure");

        finish_run();
    end

endmodule
